// File: align_top.f
+incdir+source
source/align_pkg.sv
source/align_if.sv
source/arith_pipe.sv
source/delay_comp_bridge.sv
source/align_merge.sv
source/align_top.sv
test/align_tb.sv

// File: source/align_defs.svh
// Alignment unit widths and pipeline latency shared across the design
`ifndef ALIGN_DEFS_SVH
`define ALIGN_DEFS_SVH

// Operand and result width
`define ALIGN_DATA_W 32

// Sequence tag width
`define ALIGN_TAG_W 32

// Cycles from operand capture to result out of the arithmetic pipe
// Also the default depth of the tag delay chain
`define ALIGN_PIPE_LAT 3

`endif

// File: source/align_if.sv
// Joined lane bundle carrying result, overflow, tag and valid into the merge stage
`include "align_defs.svh"

interface align_if;

    // Arithmetic lane fields
    logic [`ALIGN_DATA_W-1:0] result;
    logic                     ovf;

    // Side path fields from the delay chain
    logic [`ALIGN_TAG_W-1:0]  tag;
    logic                     valid;

    // Arithmetic pipe drives only its own fields
    modport pipe (
        output result,
        output ovf
    );

    // Merge stage reads everything, no handshake back
    modport sink (
        input result,
        input ovf,
        input tag,
        input valid
    );

endinterface

// File: source/align_merge.sv
// Output register stage joining results with their tags and flagging sequence gaps
`include "align_defs.svh"

module align_merge (
    input  logic                     clk,
    input  logic                     rst_n,
    align_if.sink                    lane,
    output logic                     out_valid,
    output logic [`ALIGN_DATA_W-1:0] out_result,
    output logic                     out_ovf,
    output logic [`ALIGN_TAG_W-1:0]  out_tag,
    output logic                     out_gap
);

    // Tag of the last valid sample seen
    logic [`ALIGN_TAG_W-1:0] last_tag;
    // Set once the first valid sample has passed
    logic                    seen_first;

    // Next tag in sequence, wraps modulo 2^TAG_W
    logic [`ALIGN_TAG_W-1:0] next_tag;
    logic                    gap_d;

    assign next_tag = last_tag + 1'b1;

    // First sample after reset has nothing to compare to
    assign gap_d = lane.valid && seen_first && (lane.tag != next_tag);

    // Sequence tracking
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_tag   <= '0;
            seen_first <= 1'b0;
        end else if (lane.valid) begin
            last_tag   <= lane.tag;
            seen_first <= 1'b1;
        end
    end

    // Strobe outputs follow lane valid every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_gap   <= 1'b0;
        end else begin
            out_valid <= lane.valid;
            out_gap   <= gap_d;
        end
    end

    // Data outputs load on valid, hold across idle cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_result <= '0;
            out_ovf    <= 1'b0;
            out_tag    <= '0;
        end else if (lane.valid) begin
            out_result <= lane.result;
            out_ovf    <= lane.ovf;
            out_tag    <= lane.tag;
        end
    end

endmodule

// File: source/align_pkg.sv
// Alignment unit types shared by the arithmetic pipe and the top level
package align_pkg;

    // Opcode carried with each sample
    // Encoding is fixed at two bits
    typedef enum logic [1:0] {
        // Unsigned add, overflow is carry out
        OP_ADD = 2'b00,
        // A minus b, overflow is borrow
        OP_SUB = 2'b01,
        // Low half of unsigned product
        // Overflow when the high half is nonzero
        OP_MUL = 2'b10,
        // Bitwise xor, never overflows
        OP_XOR = 2'b11
    } arith_op_t;

endpackage

// File: source/align_top.sv
// Alignment unit top level joining the arithmetic lane and the tag delay path
`include "align_defs.svh"

module align_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  logic [`ALIGN_DATA_W-1:0] in_a,
    input  logic [`ALIGN_DATA_W-1:0] in_b,
    input  align_pkg::arith_op_t     in_op,
    input  logic [`ALIGN_TAG_W-1:0]  in_tag,
    output logic                     out_valid,
    output logic [`ALIGN_DATA_W-1:0] out_result,
    output logic                     out_ovf,
    output logic [`ALIGN_TAG_W-1:0]  out_tag,
    output logic                     out_gap
);

    // Valid bit rides on top of the tag through the delay chain
    logic [`ALIGN_TAG_W:0] tag_word_in;
    logic [`ALIGN_TAG_W:0] tag_word_out;

    align_if u_lane ();

    assign tag_word_in = {in_valid, in_tag};

    // Split the delayed word back into lane fields
    assign {u_lane.valid, u_lane.tag} = tag_word_out;

    arith_pipe u_pipe (
        .clk   (clk),
        .rst_n (rst_n),
        .a     (in_a),
        .b     (in_b),
        .op    (in_op),
        .res   (u_lane.pipe)
    );

    // Depth matches the arithmetic latency
    delay_comp_bridge #(
        .WIDTH     (`ALIGN_TAG_W + 1),
        .DELAY_CYC (`ALIGN_PIPE_LAT)
    ) u_bridge (
        .clk      (clk),
        .rst_n    (rst_n),
        .data_in  (tag_word_in),
        .data_out (tag_word_out)
    );

    align_merge u_merge (
        .clk        (clk),
        .rst_n      (rst_n),
        .lane       (u_lane.sink),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_ovf    (out_ovf),
        .out_tag    (out_tag),
        .out_gap    (out_gap)
    );

endmodule

// File: source/arith_pipe.sv
// Free-running three-stage arithmetic pipeline producing a result and overflow flag
`include "align_defs.svh"

module arith_pipe (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`ALIGN_DATA_W-1:0] a,
    input  logic [`ALIGN_DATA_W-1:0] b,
    input  align_pkg::arith_op_t     op,
    align_if.pipe                    res
);

    import align_pkg::*;

    // Stage one operand capture
    logic [`ALIGN_DATA_W-1:0] a_q;
    logic [`ALIGN_DATA_W-1:0] b_q;
    arith_op_t                op_s1;

    // Stage two intermediate, one extra bit for carry or borrow
    logic [`ALIGN_DATA_W:0]   mid_q;
    logic                     mul_hi_q;
    arith_op_t                op_s2;

    // Combinational stage two terms
    logic [2*`ALIGN_DATA_W-1:0] prod;
    logic [`ALIGN_DATA_W:0]     mid_d;

    // Opcode follows its operands through stages one and two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_s1 <= OP_ADD;
            op_s2 <= OP_ADD;
        end else begin
            op_s1 <= op;
            op_s2 <= op_s1;
        end
    end

    // Stage one, operands registered every cycle
    always_ff @(posedge clk) begin
        a_q <= a;
        b_q <= b;
    end

    // Full width product, high half only feeds the overflow flag
    assign prod = a_q * b_q;

    always_comb begin
        case (op_s1)
            OP_ADD:  mid_d = {1'b0, a_q} + {1'b0, b_q};
            // Top bit ends up set on borrow
            OP_SUB:  mid_d = {1'b0, a_q} - {1'b0, b_q};
            OP_MUL:  mid_d = {1'b0, prod[`ALIGN_DATA_W-1:0]};
            default: mid_d = {1'b0, a_q ^ b_q};
        endcase
    end

    // Stage two register
    always_ff @(posedge clk) begin
        mid_q    <= mid_d;
        mul_hi_q <= |prod[2*`ALIGN_DATA_W-1:`ALIGN_DATA_W];
    end

    // Stage three, overflow chosen by op and result driven onto the lane
    always_ff @(posedge clk) begin
        res.result <= mid_q[`ALIGN_DATA_W-1:0];
        case (op_s2)
            OP_ADD,
            OP_SUB:  res.ovf <= mid_q[`ALIGN_DATA_W];
            OP_MUL:  res.ovf <= mul_hi_q;
            default: res.ovf <= 1'b0;
        endcase
    end

endmodule

// File: source/delay_comp_bridge.sv
// Register delay chain holding a word back by a fixed cycle count to match pipe latency
`include "align_defs.svh"

module delay_comp_bridge #(
    parameter int WIDTH     = `ALIGN_TAG_W + 1,
    parameter int DELAY_CYC = `ALIGN_PIPE_LAT
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] data_in,
    output logic [WIDTH-1:0] data_out
);

    generate
        if (DELAY_CYC == 0) begin : g_bypass

            // Zero depth, nothing to compensate
            assign data_out = data_in;

        end else begin : g_chain

            // One register per cycle of delay
            logic [WIDTH-1:0] chain_q [0:DELAY_CYC-1];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    // Clear every stage so no stale valid drains out
                    for (int i = 0; i < DELAY_CYC; i++) begin
                        chain_q[i] <= '0;
                    end
                end else begin
                    chain_q[0] <= data_in;
                    // Shift by one stage per cycle
                    for (int i = 1; i < DELAY_CYC; i++) begin
                        chain_q[i] <= chain_q[i-1];
                    end
                end
            end

            // Last stage is the output, latency is exactly DELAY_CYC
            assign data_out = chain_q[DELAY_CYC-1];

        end
    endgenerate

endmodule

// File: test/align_tb.sv
// Alignment unit testbench with random samples, a reference model and a tag-order scoreboard
`include "align_defs.svh"

module align_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import align_pkg::*;

    localparam int DW = `ALIGN_DATA_W;
    localparam int TW = `ALIGN_TAG_W;
    // Back-to-back phase, then a phase with random idle cycles between samples
    localparam int N_CONT      = 200;
    localparam int N_IDLE      = 200;
    localparam int MAX_IDLE    = 3;
    localparam int RST_CYC     = 8;
    // Samples at the start that never get a skip or repeat, so the wrap stays clean
    localparam int CLEAN_RUN   = 48;
    localparam int LATENCY     = 4;
    localparam int CYCLE_LIMIT = RST_CYC + 2 + N_CONT + N_IDLE * (MAX_IDLE + 1) + 200;

    typedef struct packed {
        logic [DW-1:0] result;
        logic          ovf;
        logic [TW-1:0] tag;
        logic          gap;
        int            due;
    } exp_entry_t;

    logic            clk;
    logic            rst_n;
    logic            in_valid;
    logic [DW-1:0]   in_a;
    logic [DW-1:0]   in_b;
    arith_op_t       in_op;
    logic [TW-1:0]   in_tag;
    logic            out_valid;
    logic [DW-1:0]   out_result;
    logic            out_ovf;
    logic [TW-1:0]   out_tag;
    logic            out_gap;

    integer          seed;
    exp_entry_t      exp_q[$];
    exp_entry_t      exp_e;
    logic [DW:0]     model;
    logic [TW-1:0]   next_tag;
    logic [TW-1:0]   last_tag;
    logic            seen_first;
    int              neg_cnt = 0;
    int              cycle_cnt = 0;
    int              err_cnt = 0;
    int              timeout_cnt = 0;
    int              in_cnt = 0;
    int              out_cnt = 0;

    align_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_a       (in_a),
        .in_b       (in_b),
        .in_op      (in_op),
        .in_tag     (in_tag),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_ovf    (out_ovf),
        .out_tag    (out_tag),
        .out_gap    (out_gap)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Expected result and overflow as {ovf, result}
    function automatic logic [DW:0] arith_model(input arith_op_t op, input logic [DW-1:0] a,
                                                input logic [DW-1:0] b);
        logic [2*DW-1:0] wide;
        logic [DW-1:0]   res;
        logic            ovf;
        case (op)
            OP_ADD: begin
                wide = {{DW{1'b0}}, a} + {{DW{1'b0}}, b};
                res  = wide[DW-1:0];
                ovf  = wide[DW];
            end
            OP_SUB: begin
                res = a - b;
                // Borrow whenever the subtrahend is larger
                ovf = (a < b);
            end
            OP_MUL: begin
                wide = {{DW{1'b0}}, a} * {{DW{1'b0}}, b};
                res  = wide[DW-1:0];
                ovf  = |wide[2*DW-1:DW];
            end
            default: begin
                res = a ^ b;
                ovf = 1'b0;
            end
        endcase
        return {ovf, res};
    endfunction

    // Corner operands show up about a quarter of the time
    function automatic logic [DW-1:0] pick_operand();
        int sel;
        sel = $random(seed) & 7;
        if (sel == 0)
            return '1;
        else if (sel == 1)
            return '0;
        return $random(seed);
    endfunction

    // Tags count up by one, with occasional skips and repeats
    task automatic advance_tag(input bit inject);
        int sel;
        sel = $random(seed) & 15;
        if (inject && sel == 0)
            next_tag = next_tag + 2 + ($random(seed) & 7);
        else if (!(inject && sel == 1))
            next_tag = next_tag + 1;
    endtask

    task automatic drive_sample(input bit inject);
        @(posedge clk);
        in_valid <= 1'b1;
        in_a     <= pick_operand();
        in_b     <= pick_operand();
        in_op    <= arith_op_t'($random(seed) & 3);
        in_tag   <= next_tag;
        advance_tag(inject);
    endtask

    // Operands keep changing while idle, nothing may leak out
    task automatic drive_idle();
        @(posedge clk);
        in_valid <= 1'b0;
        in_a     <= $random(seed);
        in_b     <= $random(seed);
    endtask

    task automatic report_and_finish();
        $display("Summary: %0d errors, %0d timeouts, %0d samples in, %0d samples out",
                 err_cnt, timeout_cnt, in_cnt, out_cnt);
        if (err_cnt == 0 && timeout_cnt == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    endtask

    task automatic check_reset_state();
        if (out_valid !== 1'b0 || out_gap !== 1'b0) begin
            err_cnt++;
            $display("** Error at %0t: out_valid/out_gap not low in reset window", $time);
        end
        if (out_result !== '0 || out_ovf !== 1'b0 || out_tag !== '0) begin
            err_cnt++;
            $display("** Error at %0t: data outputs not zero in reset window", $time);
        end
    endtask

    // Expected side and compare side, both sampled mid-cycle
    always @(negedge clk) begin
        neg_cnt++;
        if (neg_cnt <= RST_CYC + 1)
            check_reset_state();
        if (rst_n && in_valid) begin
            model         = arith_model(in_op, in_a, in_b);
            exp_e.result  = model[DW-1:0];
            exp_e.ovf     = model[DW];
            exp_e.tag     = in_tag;
            exp_e.gap     = seen_first && (in_tag != last_tag + 32'd1);
            exp_e.due     = neg_cnt + LATENCY;
            exp_q.push_back(exp_e);
            last_tag      = in_tag;
            seen_first    = 1'b1;
            in_cnt++;
        end
        if (exp_q.size() > 0 && exp_q[0].due < neg_cnt) begin
            err_cnt++;
            $display("Failure at %0t: tag %h never came out within %0d cycles", $time,
                     exp_q[0].tag, LATENCY);
            exp_e = exp_q.pop_front();
        end
        if (!out_valid && out_gap) begin
            err_cnt++;
            $display("** Error at %0t: out_gap high without out_valid", $time);
        end
        if (out_valid) begin
            out_cnt++;
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("Failure at %0t: out_valid with no sample in flight", $time);
            end else begin
                exp_e = exp_q.pop_front();
                if (exp_e.due != neg_cnt) begin
                    err_cnt++;
                    $display("Failure at %0t: output came %0d cycles after its input, not %0d",
                             $time, neg_cnt - exp_e.due + LATENCY, LATENCY);
                end
                if (out_result !== exp_e.result) begin
                    err_cnt++;
                    $display("** Error at %0t: out_result got %h expected %h", $time,
                             out_result, exp_e.result);
                end
                if (out_ovf !== exp_e.ovf) begin
                    err_cnt++;
                    $display("** Error at %0t: out_ovf got %b expected %b", $time,
                             out_ovf, exp_e.ovf);
                end
                if (out_tag !== exp_e.tag) begin
                    err_cnt++;
                    $display("** Error at %0t: out_tag got %h expected %h", $time,
                             out_tag, exp_e.tag);
                end
                if (out_gap !== exp_e.gap) begin
                    err_cnt++;
                    $display("** Error at %0t: out_gap got %b expected %b for tag %h", $time,
                             out_gap, exp_e.gap, exp_e.tag);
                end
            end
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            timeout_cnt++;
            $display("Timeout: run still going after %0d cycles", CYCLE_LIMIT);
            report_and_finish();
        end
    end

    initial begin
        seed       = 32'hd3b3_4892;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_a       = '0;
        in_b       = '0;
        in_op      = OP_ADD;
        in_tag     = '0;
        // Start close to the top so the tag wraps early in the run
        next_tag   = 32'hffff_ffe0;
        last_tag   = '0;
        seen_first = 1'b0;
        repeat (RST_CYC) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        // Continuous strobes, four samples in flight
        for (int i = 0; i < N_CONT; i++) begin
            drive_sample(i >= CLEAN_RUN);
        end
        // Random idle cycles between samples
        for (int i = 0; i < N_IDLE; i++) begin
            repeat ($random(seed) & MAX_IDLE) drive_idle();
            drive_sample(1'b1);
        end
        drive_idle();
        while (exp_q.size() != 0) @(posedge clk);
        // Quiet tail, any stray out_valid gets caught by the monitor
        repeat (8) @(posedge clk);
        if (in_cnt != out_cnt) begin
            err_cnt++;
            $display("Failure: %0d samples went in but %0d came out", in_cnt, out_cnt);
        end
        report_and_finish();
    end

endmodule
